/* src/id_pkg.sv */
package id_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_AW    = 5;
    localparam int IMM_W     = 16;
    localparam int TARGET_W  = 26;
    localparam int NUM_BANKS = 2;
    localparam int BANK_INT  = 0;
    localparam int BANK_FP   = 1;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [4:0] alu_op_t;
    typedef logic [1:0] dest_sel_t;
    typedef logic [1:0] reg_src_t;

    typedef struct packed {
        opcode_t           opcode;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] shamt;
        funct_t            funct;
    } r_view_t;

    typedef struct packed {
        opcode_t           opcode;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [IMM_W-1:0]  imm;
    } i_view_t;

    typedef struct packed {
        opcode_t             opcode;
        logic [TARGET_W-1:0] target;
    } j_view_t;

    // one fetched word as seen through each instruction format.
    typedef union packed {
        r_view_t r;
        i_view_t i;
        j_view_t j;
    } inst_u;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_COP1  = 6'h11;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;
    localparam opcode_t OP_LWC1  = 6'h31;
    localparam opcode_t OP_SWC1  = 6'h39;
    // internal code for the all-zero word that no supported opcode uses.
    localparam opcode_t OP_NOP   = 6'h3f;

    localparam funct_t FN_SLL     = 6'h00;
    localparam funct_t FN_SRL     = 6'h02;
    localparam funct_t FN_JR      = 6'h08;
    localparam funct_t FN_SYSCALL = 6'h0c;
    localparam funct_t FN_ADD     = 6'h20;
    localparam funct_t FN_ADDU    = 6'h21;
    localparam funct_t FN_SUB     = 6'h22;
    localparam funct_t FN_AND     = 6'h24;
    localparam funct_t FN_OR      = 6'h25;
    localparam funct_t FN_SLT     = 6'h2a;
    localparam funct_t FN_ADD_S   = 6'h00;
    localparam funct_t FN_SUB_S   = 6'h01;
    localparam funct_t FN_MUL_S   = 6'h02;

    localparam alu_op_t ALU_ADD  = 5'd0;
    localparam alu_op_t ALU_SUB  = 5'd1;
    localparam alu_op_t ALU_AND  = 5'd2;
    localparam alu_op_t ALU_OR   = 5'd3;
    localparam alu_op_t ALU_SLT  = 5'd4;
    localparam alu_op_t ALU_SLL  = 5'd5;
    localparam alu_op_t ALU_SRL  = 5'd6;
    localparam alu_op_t ALU_LUI  = 5'd7;
    localparam alu_op_t ALU_SNE  = 5'd8;
    localparam alu_op_t ALU_FADD = 5'd16;
    localparam alu_op_t ALU_FSUB = 5'd17;
    localparam alu_op_t ALU_FMUL = 5'd18;
    localparam alu_op_t ALU_NONE = 5'd31;

    localparam dest_sel_t DEST_RT = 2'd0;
    localparam dest_sel_t DEST_RD = 2'd1;
    localparam dest_sel_t DEST_RA = 2'd2;

    localparam reg_src_t SRC_ALU     = 2'd0;
    localparam reg_src_t SRC_MEM     = 2'd1;
    localparam reg_src_t SRC_PC_LINK = 2'd2;

endpackage

/* src/reg_port_if.sv */
`timescale 1ns/1ps

interface reg_port_if;
    import id_pkg::*;

    logic [REG_AW-1:0] rs_num;
    logic [REG_AW-1:0] rt_num;
    logic [WORD_W-1:0] rs_data;
    logic [WORD_W-1:0] rt_data;
    logic [REG_AW-1:0] rd_num;
    logic [WORD_W-1:0] rd_data;
    logic              rd_we;

    modport bank (
        input  rs_num,
        input  rt_num,
        input  rd_num,
        input  rd_data,
        input  rd_we,
        output rs_data,
        output rt_data
    );

    modport client (
        output rs_num,
        output rt_num,
        output rd_num,
        output rd_data,
        output rd_we,
        input  rs_data,
        input  rt_data
    );

endinterface

/* src/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if;
    import id_pkg::*;

    dest_sel_t destination_register;
    logic      alu_src;
    alu_op_t   alu_op;
    logic      register_write;
    logic      fregister_write;
    reg_src_t  register_src;

    logic      jump;
    logic      jump_register;
    logic      branch;
    logic      pc_enable;

    logic      we_memory;
    logic      we_cache;
    logic      cache_input_type;
    logic      set_dirty;
    logic      set_valid;
    logic      memory_address_type;
    logic      is_word;

    logic      is_nop;

    modport src (
        output destination_register, alu_src, alu_op, register_write,
        output fregister_write, register_src,
        output jump, jump_register, branch, pc_enable,
        output we_memory, we_cache, cache_input_type, set_dirty, set_valid,
        output memory_address_type, is_word, is_nop
    );

    modport dst (
        input  destination_register, alu_src, alu_op, register_write,
        input  fregister_write, register_src,
        input  jump, jump_register, branch, pc_enable,
        input  we_memory, we_cache, cache_input_type, set_dirty, set_valid,
        input  memory_address_type, is_word, is_nop
    );

endinterface

/* src/regfile.sv */
`timescale 1ns/1ps

module regfile #(
    parameter bit zero_reg = 1'b1
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       halted,
    reg_port_if.bank   port
);
    import id_pkg::*;

    logic [WORD_W-1:0] regs [2**REG_AW];
    logic              wr_en;
    logic              rs_is_zero;
    logic              rt_is_zero;

    // a halted pipeline must not retire anything more.
    assign wr_en = port.rd_we && !halted && !(zero_reg && port.rd_num == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[port.rd_num] <= port.rd_data;
        end
    end

    // a write shows up on the read ports only after its edge.
    assign rs_is_zero = zero_reg && port.rs_num == '0;
    assign rt_is_zero = zero_reg && port.rt_num == '0;

    assign port.rs_data = rs_is_zero ? '0 : regs[port.rs_num];
    assign port.rt_data = rt_is_zero ? '0 : regs[port.rt_num];

    property p_write_lands;
        logic [REG_AW-1:0] num;
        logic [WORD_W-1:0] data;
        @(posedge clk) disable iff (rst)
            (wr_en, num = port.rd_num, data = port.rd_data) |=> (regs[num] == data);
    endproperty

    a_write_lands: assert property (p_write_lands)
        else $error("register write did not land in the bank");

endmodule

/* src/id_decoder.sv */
`timescale 1ns/1ps

module id_decoder (
    input  id_pkg::inst_u             inst,
    ctrl_if.src                       ctrl,
    output logic [id_pkg::WORD_W-1:0] imm_extend
);
    import id_pkg::*;

    opcode_t opcode;
    logic    imm_zero_ext;
    logic    imm_upper;

    // an all-zero word is sll $0,$0,0 and is kept apart as a bubble.
    assign opcode = (inst == '0) ? OP_NOP : inst.r.opcode;

    always_comb begin
        ctrl.destination_register = DEST_RT;
        ctrl.alu_src              = 1'b0;
        ctrl.alu_op               = ALU_NONE;
        ctrl.register_write       = 1'b0;
        ctrl.fregister_write      = 1'b0;
        ctrl.register_src         = SRC_ALU;
        ctrl.jump                 = 1'b0;
        ctrl.jump_register        = 1'b0;
        ctrl.branch               = 1'b0;
        ctrl.pc_enable            = 1'b1;
        ctrl.we_memory            = 1'b0;
        ctrl.we_cache             = 1'b0;
        ctrl.cache_input_type     = 1'b0;
        ctrl.set_dirty            = 1'b0;
        ctrl.set_valid            = 1'b0;
        ctrl.memory_address_type  = 1'b0;
        ctrl.is_word              = 1'b0;
        ctrl.is_nop               = 1'b0;
        imm_zero_ext              = 1'b0;
        imm_upper                 = 1'b0;

        case (opcode)
            OP_NOP: begin
                ctrl.is_nop = 1'b1;
            end
            OP_RTYPE: begin
                ctrl.destination_register = DEST_RD;
                ctrl.register_write       = 1'b1;
                case (inst.r.funct)
                    FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUB:          ctrl.alu_op = ALU_SUB;
                    FN_AND:          ctrl.alu_op = ALU_AND;
                    FN_OR:           ctrl.alu_op = ALU_OR;
                    FN_SLT:          ctrl.alu_op = ALU_SLT;
                    FN_SLL:          ctrl.alu_op = ALU_SLL;
                    FN_SRL:          ctrl.alu_op = ALU_SRL;
                    FN_JR: begin
                        ctrl.register_write = 1'b0;
                        ctrl.jump_register  = 1'b1;
                    end
                    FN_SYSCALL: begin
                        // freezing fetch halts the machine.
                        ctrl.register_write = 1'b0;
                        ctrl.pc_enable      = 1'b0;
                    end
                    default: ctrl.register_write = 1'b0;
                endcase
            end
            OP_J: begin
                ctrl.jump = 1'b1;
            end
            OP_JAL: begin
                ctrl.jump                 = 1'b1;
                ctrl.register_write       = 1'b1;
                ctrl.destination_register = DEST_RA;
                ctrl.register_src         = SRC_PC_LINK;
            end
            OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;
            end
            OP_BNE: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SNE;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI: begin
                ctrl.alu_src        = 1'b1;
                ctrl.register_write = 1'b1;
                case (opcode)
                    OP_SLTI: ctrl.alu_op = ALU_SLT;
                    OP_ANDI: ctrl.alu_op = ALU_AND;
                    OP_ORI:  ctrl.alu_op = ALU_OR;
                    OP_LUI:  ctrl.alu_op = ALU_LUI;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
                imm_zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) ||
                               (opcode == OP_ADDIU);
                imm_upper    = (opcode == OP_LUI);
            end
            OP_LW, OP_LWC1: begin
                ctrl.alu_src             = 1'b1;
                ctrl.alu_op              = ALU_ADD;
                ctrl.register_src        = SRC_MEM;
                ctrl.is_word             = 1'b1;
                ctrl.set_valid           = 1'b1;
                ctrl.memory_address_type = 1'b1;
                ctrl.register_write      = (opcode == OP_LW);
                ctrl.fregister_write     = (opcode == OP_LWC1);
            end
            OP_SW, OP_SWC1: begin
                ctrl.alu_src          = 1'b1;
                ctrl.alu_op           = ALU_ADD;
                ctrl.we_memory        = 1'b1;
                ctrl.we_cache         = 1'b1;
                ctrl.set_dirty        = 1'b1;
                ctrl.cache_input_type = 1'b1;
            end
            OP_COP1: begin
                ctrl.destination_register = DEST_RD;
                ctrl.fregister_write      = 1'b1;
                case (inst.r.funct)
                    FN_ADD_S: ctrl.alu_op = ALU_FADD;
                    FN_SUB_S: ctrl.alu_op = ALU_FSUB;
                    FN_MUL_S: ctrl.alu_op = ALU_FMUL;
                    default:  ctrl.fregister_write = 1'b0;
                endcase
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        if (imm_upper) begin
            imm_extend = {inst.i.imm, {IMM_W{1'b0}}};
        end else if (imm_zero_ext) begin
            imm_extend = {{(WORD_W-IMM_W){1'b0}}, inst.i.imm};
        end else begin
            imm_extend = {{(WORD_W-IMM_W){inst.i.imm[IMM_W-1]}}, inst.i.imm};
        end
    end

endmodule

/* src/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [id_pkg::WORD_W-1:0]                inst,
    input  logic [id_pkg::WORD_W-1:0]                inst_addr_in,
    input  logic [id_pkg::WORD_W-1:0]                rd_data,
    input  logic [id_pkg::WORD_W-1:0]                frd_data,
    input  logic [id_pkg::REG_AW-1:0]                rd_num,
    input  logic                                     register_write_in,
    input  logic                                     fregister_write_in,
    input  logic                                     last_stage_halted,
    output logic [id_pkg::WORD_W-1:0]                rs_data,
    output logic [id_pkg::WORD_W-1:0]                rt_data,
    output logic [id_pkg::WORD_W-1:0]                frs_data,
    output logic [id_pkg::WORD_W-1:0]                frt_data,
    output logic [$bits(id_pkg::funct_t)-1:0]        inst_50,
    output logic [id_pkg::REG_AW-1:0]                inst_2016,
    output logic [id_pkg::REG_AW-1:0]                inst_1511,
    output logic [id_pkg::REG_AW-1:0]                inst_106,
    output logic [id_pkg::TARGET_W-1:0]              jea,
    output logic [id_pkg::WORD_W-1:0]                imm_extend,
    output logic [$bits(id_pkg::dest_sel_t)-1:0]     destination_register,
    output logic                                     alu_src,
    output logic [$bits(id_pkg::alu_op_t)-1:0]       alu_op,
    output logic                                     register_write_out,
    output logic                                     fregister_write_out,
    output logic [$bits(id_pkg::reg_src_t)-1:0]      register_src,
    output logic                                     jump,
    output logic                                     jump_register,
    output logic                                     branch,
    output logic                                     pc_enable,
    output logic                                     is_nop,
    output logic                                     halted,
    output logic                                     we_memory,
    output logic                                     we_cache,
    output logic                                     cache_input_type,
    output logic                                     set_dirty,
    output logic                                     set_valid,
    output logic                                     memory_address_type,
    output logic                                     is_word
);
    import id_pkg::*;

    inst_u             inst_w;
    logic [WORD_W-1:0] bank_wdata [NUM_BANKS];
    logic [NUM_BANKS-1:0] bank_we;

    ctrl_if     ctrl ();
    reg_port_if bank_port [NUM_BANKS] ();

    // inst_addr_in only rides along to later stages for the jal link.
    assign inst_w    = inst;
    assign inst_50   = inst_w.r.funct;
    assign inst_2016 = inst_w.r.rt;
    assign inst_1511 = inst_w.r.rd;
    assign inst_106  = inst_w.r.shamt;
    assign jea       = inst_w.j.target;
    assign halted    = last_stage_halted;

    assign bank_we[BANK_INT]    = register_write_in;
    assign bank_we[BANK_FP]     = fregister_write_in;
    assign bank_wdata[BANK_INT] = rd_data;
    assign bank_wdata[BANK_FP]  = frd_data;

    id_decoder u_decoder (
        .inst       (inst_w),
        .ctrl       (ctrl),
        .imm_extend (imm_extend)
    );

    // both banks read the same rs and rt numbers.
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign bank_port[b].rs_num  = inst_w.r.rs;
        assign bank_port[b].rt_num  = inst_w.r.rt;
        assign bank_port[b].rd_num  = rd_num;
        assign bank_port[b].rd_data = bank_wdata[b];
        assign bank_port[b].rd_we   = bank_we[b];

        regfile #(
            .zero_reg (b == BANK_INT)
        ) u_regfile (
            .clk    (clk),
            .rst    (rst),
            .halted (last_stage_halted),
            .port   (bank_port[b])
        );
    end

    assign rs_data  = bank_port[BANK_INT].rs_data;
    assign rt_data  = bank_port[BANK_INT].rt_data;
    assign frs_data = bank_port[BANK_FP].rs_data;
    assign frt_data = bank_port[BANK_FP].rt_data;

    assign destination_register = ctrl.destination_register;
    assign alu_src              = ctrl.alu_src;
    assign alu_op               = ctrl.alu_op;
    assign register_write_out   = ctrl.register_write;
    assign fregister_write_out  = ctrl.fregister_write;
    assign register_src         = ctrl.register_src;
    assign jump                 = ctrl.jump;
    assign jump_register        = ctrl.jump_register;
    assign branch               = ctrl.branch;
    assign pc_enable            = ctrl.pc_enable;
    assign is_nop               = ctrl.is_nop;
    assign we_memory            = ctrl.we_memory;
    assign we_cache             = ctrl.we_cache;
    assign cache_input_type     = ctrl.cache_input_type;
    assign set_dirty            = ctrl.set_dirty;
    assign set_valid            = ctrl.set_valid;
    assign memory_address_type  = ctrl.memory_address_type;
    assign is_word              = ctrl.is_word;

    // write-back retires one instruction, so only one bank is written.
    a_one_bank_write: assert property (@(posedge clk) disable iff (rst)
        !(register_write_in && fregister_write_in))
        else $error("integer and floating point write-back in the same cycle");

endmodule

/* verification/id_checks.svh */
`ifndef ID_CHECKS_SVH
`define ID_CHECKS_SVH

task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                          input logic [WORD_W-1:0] act);
    num_checks++;
    if (act !== exp) begin
        stop_with_failure($sformatf("Error %s: expected 0x%h, actual 0x%h", name, exp, act));
    end
endtask

task automatic check_alu_op(input string name, input alu_op_t exp, input alu_op_t act);
    num_checks++;
    if (act !== exp) begin
        stop_with_failure($sformatf("Error %s: expected 0x%h, actual 0x%h", name, exp, act));
    end
endtask

task automatic check_dest(input string name, input dest_sel_t exp, input dest_sel_t act);
    num_checks++;
    if (act !== exp) begin
        stop_with_failure($sformatf("Error %s: expected 0x%h, actual 0x%h", name, exp, act));
    end
endtask

task automatic check_src(input string name, input reg_src_t exp, input reg_src_t act);
    num_checks++;
    if (act !== exp) begin
        stop_with_failure($sformatf("Error %s: expected 0x%h, actual 0x%h", name, exp, act));
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    num_checks++;
    if (act !== exp) begin
        stop_with_failure($sformatf("Error %s: expected 0x%h, actual 0x%h", name, exp, act));
    end
endtask

`endif

/* verification/id_stage_tb.sv */
`timescale 1ns/1ps

module id_stage_tb;
    import id_pkg::*;

    localparam int          CLK_HALF   = 50;
    localparam int          CLK_PERIOD = 2 * CLK_HALF;
    localparam int          RST_CYCLES = 3;
    localparam int          NUM_REGS   = 2**REG_AW;
    localparam logic [31:0] LFSR_SEED  = 32'hd9ed_9aac;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    localparam              GOLDEN     = "verification/id_golden.txt";

    logic              clk;
    logic              rst;
    logic [WORD_W-1:0] inst;
    logic [WORD_W-1:0] inst_addr_in;
    logic [WORD_W-1:0] rd_data;
    logic [WORD_W-1:0] frd_data;
    logic [REG_AW-1:0] rd_num;
    logic              register_write_in;
    logic              fregister_write_in;
    logic              last_stage_halted;

    logic [WORD_W-1:0]   rs_data;
    logic [WORD_W-1:0]   rt_data;
    logic [WORD_W-1:0]   frs_data;
    logic [WORD_W-1:0]   frt_data;
    funct_t              inst_50;
    logic [REG_AW-1:0]   inst_2016;
    logic [REG_AW-1:0]   inst_1511;
    logic [REG_AW-1:0]   inst_106;
    logic [TARGET_W-1:0] jea;
    logic [WORD_W-1:0]   imm_extend;
    dest_sel_t           destination_register;
    logic                alu_src;
    alu_op_t             alu_op;
    logic                register_write_out;
    logic                fregister_write_out;
    reg_src_t            register_src;
    logic                jump;
    logic                jump_register;
    logic                branch;
    logic                pc_enable;
    logic                is_nop;
    logic                halted;
    logic                we_memory;
    logic                we_cache;
    logic                cache_input_type;
    logic                set_dirty;
    logic                set_valid;
    logic                memory_address_type;
    logic                is_word;

    // expected bank contents as the write rules leave them.
    logic [WORD_W-1:0] shadow [NUM_BANKS][NUM_REGS];
    logic              halt_level;
    logic [31:0]       lfsr_state;
    int                lfsr_steps;
    int                num_checks;
    int                budget_cycles;

    id_stage UUT (.*);

    always #CLK_HALF clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    `include "id_checks.svh"

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // the output bit is the lsb taken before each single-bit step.
    task automatic take_random_word(output logic [31:0] value);
        value = '0;
        for (int i = 0; i < 32; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
            lfsr_steps++;
        end
    endtask

    task automatic check_reads(input logic [31:0] word);
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        rs = word[25:21];
        rt = word[20:16];
        check_word("rs_data", shadow[BANK_INT][rs], rs_data);
        check_word("rt_data", shadow[BANK_INT][rt], rt_data);
        check_word("frs_data", shadow[BANK_FP][rs], frs_data);
        check_word("frt_data", shadow[BANK_FP][rt], frt_data);
        check_bit("halted", halt_level, halted);
    endtask

    task automatic apply_write(input int bank, input int num, input logic [31:0] value);
        @(posedge clk);
        rd_num             <= REG_AW'(num);
        rd_data            <= (bank == BANK_INT) ? value : ~value;
        frd_data           <= (bank == BANK_FP) ? value : ~value;
        register_write_in  <= (bank == BANK_INT);
        fregister_write_in <= (bank == BANK_FP);
        @(negedge clk);
        check_bit("halted", halt_level, halted);
        // lands on the next edge unless halted or aimed at integer r0.
        if (!halt_level && !(bank == BANK_INT && num == 0)) begin
            shadow[bank][num] = value;
        end
    endtask

    task automatic sweep_banks();
        logic [31:0] word;
        for (int i = 0; i < NUM_REGS / 2; i++) begin
            word = {6'h00, REG_AW'(i), REG_AW'(i + NUM_REGS / 2), 16'h0000};
            @(posedge clk);
            inst               <= word;
            register_write_in  <= 1'b0;
            fregister_write_in <= 1'b0;
            @(negedge clk);
            check_reads(word);
        end
    endtask

    task automatic run_decode(input string line);
        logic [31:0] word;
        alu_op_t     exp_alu;
        dest_sel_t   exp_dest;
        reg_src_t    exp_src;
        logic [14:0] f;
        logic [31:0] exp_imm;
        int          n;
        n = $sscanf(line, "D %h %h %h %h %b %h", word, exp_alu, exp_dest, exp_src, f, exp_imm);
        if (n != 6) begin
            stop_with_failure($sformatf("malformed decode record: %s", line));
        end
        @(posedge clk);
        inst               <= word;
        register_write_in  <= 1'b0;
        fregister_write_in <= 1'b0;
        @(negedge clk);
        check_reads(word);
        check_word("inst_50", word[5:0], inst_50);
        check_word("inst_2016", word[20:16], inst_2016);
        check_word("inst_1511", word[15:11], inst_1511);
        check_word("inst_106", word[10:6], inst_106);
        check_word("jea", word[25:0], jea);
        check_word("imm_extend", exp_imm, imm_extend);
        check_alu_op("alu_op", exp_alu, alu_op);
        check_dest("destination_register", exp_dest, destination_register);
        check_src("register_src", exp_src, register_src);
        check_bit("alu_src", f[14], alu_src);
        check_bit("register_write_out", f[13], register_write_out);
        check_bit("fregister_write_out", f[12], fregister_write_out);
        check_bit("jump", f[11], jump);
        check_bit("jump_register", f[10], jump_register);
        check_bit("branch", f[9], branch);
        check_bit("pc_enable", f[8], pc_enable);
        check_bit("is_nop", f[7], is_nop);
        check_bit("we_memory", f[6], we_memory);
        check_bit("we_cache", f[5], we_cache);
        check_bit("cache_input_type", f[4], cache_input_type);
        check_bit("set_dirty", f[3], set_dirty);
        check_bit("set_valid", f[2], set_valid);
        check_bit("memory_address_type", f[1], memory_address_type);
        check_bit("is_word", f[0], is_word);
    endtask

    task automatic run_record(input string line);
        int          bank;
        int          num;
        int          steps;
        int          level;
        logic [31:0] value;
        case (line[0])
            "S": sweep_banks();
            "D": run_decode(line);
            "W": begin
                void'($sscanf(line, "W %d %d %h", bank, num, value));
                apply_write(bank, num, value);
            end
            "L": begin
                void'($sscanf(line, "L %d %d %d", bank, num, steps));
                take_random_word(value);
                if (lfsr_steps != steps) begin
                    stop_with_failure($sformatf("LFSR is at step %0d but the record says %0d",
                                                lfsr_steps, steps));
                end
                apply_write(bank, num, value);
            end
            "H": begin
                void'($sscanf(line, "H %d", level));
                @(posedge clk);
                last_stage_halted  <= level[0];
                register_write_in  <= 1'b0;
                fregister_write_in <= 1'b0;
                @(negedge clk);
                halt_level = level[0];
                check_bit("halted", halt_level, halted);
            end
            default: stop_with_failure($sformatf("unknown record kind in line: %s", line));
        endcase
    endtask

    initial begin
        string line;
        string records[$];
        int    fd;
        int    sweeps;
        clk                = 1'b0;
        rst                = 1'b1;
        inst               = '0;
        inst_addr_in       = '0;
        rd_data            = '0;
        frd_data           = '0;
        rd_num             = '0;
        register_write_in  = 1'b0;
        fregister_write_in = 1'b0;
        last_stage_halted  = 1'b0;
        halt_level         = 1'b0;
        lfsr_state         = LFSR_SEED;
        lfsr_steps         = 0;
        num_checks         = 0;
        sweeps             = 0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                shadow[b][r] = '0;
            end
        end

        fd = $fopen(GOLDEN, "r");
        if (fd == 0) begin
            stop_with_failure("could not open the golden file");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 0 && line[0] != "#" && line[0] != "\n" && line[0] != " ") begin
                records.push_back(line);
                if (line[0] == "S") begin
                    sweeps++;
                end
            end
        end
        $fclose(fd);
        // a sweep spans half the register count in cycles.
        budget_cycles = records.size() + sweeps * (NUM_REGS / 2) + RST_CYCLES + 10;

        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        foreach (records[k]) begin
            run_record(records[k]);
        end

        if (num_checks > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            stop_with_failure("the golden file produced no checks");
        end
        $finish;
    end

    initial begin
        wait (budget_cycles > 0);
        #(budget_cycles * CLK_PERIOD);
        stop_with_failure("timeout: the run did not finish within the expected time");
    end

endmodule

/* sources.f */
src/id_pkg.sv
src/reg_port_if.sv
src/ctrl_if.sv
src/regfile.sv
src/id_decoder.sv
src/id_stage.sv
+incdir+verification
verification/id_stage_tb.sv

/* verification/id_golden.txt */
# S | D inst alu_op dest src flags imm_extend | W bank reg value | L bank reg lfsr_steps | H halt
# flags: alu_src rw frw jump jr branch pc_en nop we_mem we_cache cit dirty valid mat is_word
S
D 00000000 1f 0 0 000000110000000 00000000
W 0 1 12345678
W 0 2 89abcdef
D 00221820 00 1 0 010000100000000 00001820
W 1 1 3f800000
W 1 2 40000000
W 0 0 deadbeef
W 1 0 cafef00d
L 0 5 32
L 0 6 64
L 1 16 96
L 1 2 128
H 1
W 0 1 0badf00d
L 1 1 160
H 0
S
D 00a62021 00 1 0 010000100000000 00002021
D 00223822 01 1 0 010000100000000 00003822
D 00224024 02 1 0 010000100000000 00004024
D 00224825 03 1 0 010000100000000 00004825
D 0022502a 04 1 0 010000100000000 0000502a
D 00025900 05 1 0 010000100000000 00005900
D 000267c2 06 1 0 010000100000000 000067c2
D 0000000c 1f 1 0 000000000000000 0000000c
D 2025fffc 00 0 0 110000100000000 fffffffc
D 24268000 00 0 0 110000100000000 00008000
D 28278001 04 0 0 110000100000000 ffff8001
D 3028f0f0 02 0 0 110000100000000 0000f0f0
D 34299abc 03 0 0 110000100000000 00009abc
D 3c0abeef 07 0 0 110000100000000 beef0000
D 8c2bfff8 00 0 1 110000100000111 fffffff8
D ac22000c 00 0 0 100000101111000 0000000c
D 1022ffff 01 0 0 000001100000000 ffffffff
D 14220010 08 0 0 000001100000000 00000010
D 08123456 1f 0 0 000100100000000 00003456
D 0fffffff 1f 2 2 010100100000000 ffffffff
D 46021840 10 1 0 001000100000000 00001840
D 46021841 11 1 0 001000100000000 00001841
D 46021842 12 1 0 001000100000000 00001842
D c4240004 00 0 1 101000100000111 00000004
D e425fffe 00 0 0 100000101111000 fffffffe
W 0 31 00400020
D 03e00008 1f 1 0 000010100000000 00000008
